/* vlog.f */
rtl/irq_gen_pkg.sv
rtl/irq_gen_regs.sv
rtl/irq_rnd_source.sv
rtl/irq_mode_ctrl.sv
rtl/irq_gen_top.sv
bench/irq_gen_sva.sv
bench/tb_irq_gen.sv

/* bench/tb_irq_gen.sv */
// Interrupt generator testbench
// Drives AXI4-Lite accesses and core side stimulus, checks register
// access, software, PC-triggered, random and standard modes against
// reference functions, and prints an error summary

`timescale 1ns/1ps
`default_nettype none

module tb_irq_gen;

  // Forty random interrupts of up to 200 cycles, doubled for redraws and
  // bus traffic, plus the register, software and PC-triggered tests
  localparam int TIMEOUT_CYCLES = 2 * 40 * 200 + 4000;

  logic                    clk_i;
  logic                    rst_ni;
  irq_gen_pkg::axil_req_t  axil_req;
  irq_gen_pkg::axil_rsp_t  axil_rsp;
  irq_gen_pkg::pc_t        pc;
  logic                    irq_ack;
  irq_gen_pkg::irq_id_t    irq_ack_id;
  irq_gen_pkg::irq_lines_t irq_lines;

  irq_gen_pkg::irq_lines_t exp_lines;
  logic                    check_en;
  int                      cyc;
  int                      fire_cyc;
  int                      err_lines;
  int                      err_bus;
  int                      err_rnd;
  logic [31:0]             lfsr_state;

  irq_gen_top #(.LFSR_SEED(32'h5A3C_96E1)) i_irq_gen_top (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .axil_req_i   (axil_req),
    .axil_rsp_o   (axil_rsp),
    .pc_i         (pc),
    .irq_ack_i    (irq_ack),
    .irq_ack_id_i (irq_ack_id),
    .irq_lines_o  (irq_lines)
  );

  ////////////////////////////////////////////////////////////
  // Reference functions and random source
  ////////////////////////////////////////////////////////////

  // Word bit 3 software, 7 timer, 11 external, 16..63 fast
  function automatic irq_gen_pkg::irq_lines_t map_word(irq_gen_pkg::irq_word_t w);
    irq_gen_pkg::irq_lines_t l;
    l.software = w[3];
    l.timer    = w[7];
    l.external = w[11];
    l.fast     = w[63:16];
    return l;
  endfunction

  // Nonzero and only lines whose id lies within the bounds
  function automatic bit rnd_legal(irq_gen_pkg::irq_lines_t l, int lo, int hi);
    irq_gen_pkg::irq_word_t m;
    for (int i = 0; i < 64; i++) begin
      m[i] = (i >= lo) && (i <= hi);
    end
    return (l != '0) && ((l & ~map_word(m)) == '0);
  endfunction

  // Fibonacci LFSR, taps 32 22 2 1, one step per bit
  function automatic logic [31:0] rand_bits(int n);
    logic [31:0] r;
    logic        fb;
    r = '0;
    for (int i = 0; i < n; i++) begin
      fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
      lfsr_state = {lfsr_state[30:0], fb};
      r = {r[30:0], fb};
    end
    return r;
  endfunction

  ////////////////////////////////////////////////////////////
  // Clock, cycle count and line comparison
  ////////////////////////////////////////////////////////////

  initial begin
    clk_i = 1'b0;
    forever #4 clk_i = ~clk_i;
  end

  always @(posedge clk_i) begin
    cyc <= cyc + 1;
    if (cyc >= TIMEOUT_CYCLES) begin
      $display("Timeout after %0d cycles, a handshake or interrupt never came", cyc);
      $display("** FAIL **");
      $finish;
    end
  end

  always @(posedge clk_i) begin
    if (rst_ni && check_en && irq_lines !== exp_lines) begin
      err_lines++;
      $display("FAIL %0t irq_lines_o expected %h got %h", $time, exp_lines, irq_lines);
    end
  end

  ////////////////////////////////////////////////////////////
  // AXI4-Lite driver, entered and left just after a falling edge
  ////////////////////////////////////////////////////////////

  task automatic axil_write(input irq_gen_pkg::axil_addr_t addr, input logic [31:0] data,
                            input logic [3:0] strb, output irq_gen_pkg::axil_resp_t resp);
    int lag;
    lag = int'(rand_bits(2));
    axil_req.aw_addr  = addr;
    axil_req.aw_valid = 1'b1;
    axil_req.w_data   = data;
    axil_req.w_strb   = strb;
    axil_req.w_valid  = 1'b1;
    do @(posedge clk_i); while (!axil_rsp.aw_ready);
    // Address and data are taken in the same cycle
    if (axil_rsp.w_ready !== 1'b1) begin
      err_bus++;
      $display("FAIL %0t w_ready expected 1 got %b", $time, axil_rsp.w_ready);
    end
    @(negedge clk_i);
    axil_req.aw_valid = 1'b0;
    axil_req.w_valid  = 1'b0;
    fire_cyc = cyc;
    repeat (lag) @(negedge clk_i);
    axil_req.b_ready = 1'b1;
    do @(posedge clk_i); while (!axil_rsp.b_valid);
    resp = axil_rsp.b_resp;
    @(negedge clk_i);
    axil_req.b_ready = 1'b0;
  endtask

  task automatic axil_read(input irq_gen_pkg::axil_addr_t addr, output logic [31:0] data,
                           output irq_gen_pkg::axil_resp_t resp);
    int lag;
    lag = int'(rand_bits(2));
    axil_req.ar_addr  = addr;
    axil_req.ar_valid = 1'b1;
    do @(posedge clk_i); while (!axil_rsp.ar_ready);
    @(negedge clk_i);
    axil_req.ar_valid = 1'b0;
    repeat (lag) @(negedge clk_i);
    axil_req.r_ready = 1'b1;
    do @(posedge clk_i); while (!axil_rsp.r_valid);
    data = axil_rsp.r_data;
    resp = axil_rsp.r_resp;
    @(negedge clk_i);
    axil_req.r_ready = 1'b0;
  endtask

  // Full word write that must answer OKAY
  task automatic write_reg(input irq_gen_pkg::axil_addr_t addr, input logic [31:0] data);
    irq_gen_pkg::axil_resp_t resp;
    axil_write(addr, data, 4'hF, resp);
    if (resp !== irq_gen_pkg::RESP_OKAY) begin
      err_bus++;
      $display("FAIL %0t b_resp expected %h got %h", $time, irq_gen_pkg::RESP_OKAY, resp);
    end
  endtask

  task automatic check_read(input irq_gen_pkg::axil_addr_t addr, input logic [31:0] exp_data,
                            input irq_gen_pkg::axil_resp_t exp_resp);
    logic [31:0]             data;
    irq_gen_pkg::axil_resp_t resp;
    axil_read(addr, data, resp);
    if (data !== exp_data) begin
      err_bus++;
      $display("FAIL %0t r_data expected %h got %h", $time, exp_data, data);
    end
    if (resp !== exp_resp) begin
      err_bus++;
      $display("FAIL %0t r_resp expected %h got %h", $time, exp_resp, resp);
    end
  endtask

  // New expectation from the second cycle after b_valid of the last write
  task automatic expect_lines(input irq_gen_pkg::irq_lines_t value);
    while (cyc < fire_cyc + 1) @(negedge clk_i);
    exp_lines = value;
    check_en  = 1'b1;
  endtask

  task automatic pulse_ack(input irq_gen_pkg::irq_id_t id);
    irq_ack    = 1'b1;
    irq_ack_id = id;
    @(negedge clk_i);
    irq_ack    = 1'b0;
  endtask

  ////////////////////////////////////////////////////////////
  // Test sequence
  ////////////////////////////////////////////////////////////

  initial begin
    logic [31:0]             shadow [8];
    logic [31:0]             wmask  [8];
    logic [31:0]             d;
    logic [3:0]              s;
    irq_gen_pkg::axil_resp_t resp;
    irq_gen_pkg::irq_word_t  sw;
    irq_gen_pkg::irq_lines_t val;
    irq_gen_pkg::irq_id_t    id;
    logic [31:0]             trig;
    int                      min_c;
    int                      min_i;
    int                      max_i;
    int                      ref_cyc;

    lfsr_state = 32'h17b2_49e6;
    cyc = 0;
    err_lines = 0;
    err_bus = 0;
    err_rnd = 0;
    axil_req = '0;
    pc = '0;
    irq_ack = 1'b0;
    irq_ack_id = '0;
    exp_lines = '0;
    check_en = 1'b1;
    rst_ni = 1'b0;
    repeat (2) @(negedge clk_i);
    rst_ni = 1'b1;
    @(negedge clk_i);

    // Register access with strobes, mode may wander so lines are not checked
    check_en = 1'b0;
    wmask = '{32'h3, 32'hFFFF, 32'hFFFF, 32'h3F, 32'h3F, '1, '1, '1};
    for (int k = 0; k < 8; k++) shadow[k] = '0;
    repeat (3) begin
      for (int k = 0; k < 8; k++) begin
        d = rand_bits(32);
        s = rand_bits(4);
        for (int b = 0; b < 4; b++) begin
          if (s[b]) shadow[k][8*b +: 8] = d[8*b +: 8];
        end
        shadow[k] &= wmask[k];
        axil_write(8'(4 * k), d, s, resp);
        if (resp !== irq_gen_pkg::RESP_OKAY) begin
          err_bus++;
          $display("FAIL %0t b_resp expected %h got %h", $time, irq_gen_pkg::RESP_OKAY, resp);
        end
        check_read(8'(4 * k), shadow[k], irq_gen_pkg::RESP_OKAY);
      end
    end
    // Read-only and unmapped targets
    axil_write(irq_gen_pkg::REG_ACK_ID, '1, 4'hF, resp);
    if (resp !== irq_gen_pkg::RESP_SLVERR) begin
      err_bus++;
      $display("FAIL %0t b_resp expected %h got %h", $time, irq_gen_pkg::RESP_SLVERR, resp);
    end
    axil_write(8'h24, '1, 4'hF, resp);
    if (resp !== irq_gen_pkg::RESP_SLVERR) begin
      err_bus++;
      $display("FAIL %0t b_resp expected %h got %h", $time, irq_gen_pkg::RESP_SLVERR, resp);
    end
    check_read(8'h24, '0, irq_gen_pkg::RESP_SLVERR);
    check_read(8'h06, '0, irq_gen_pkg::RESP_SLVERR);
    write_reg(irq_gen_pkg::REG_MODE, irq_gen_pkg::STANDARD);
    expect_lines('0);

    // Software-defined mode, then back to standard
    repeat (3) begin
      sw = {rand_bits(32), rand_bits(32)};
      check_en = 1'b0;
      write_reg(irq_gen_pkg::REG_MODE, irq_gen_pkg::SOFTWARE_DEFINED);
      write_reg(irq_gen_pkg::REG_SW_LO, sw[31:0]);
      write_reg(irq_gen_pkg::REG_SW_HI, sw[63:32]);
      expect_lines(map_word(sw));
      repeat (6) @(negedge clk_i);
      // Lines may drop before the write response is taken
      check_en = 1'b0;
      write_reg(irq_gen_pkg::REG_MODE, irq_gen_pkg::STANDARD);
      expect_lines('0);
      repeat (3) @(negedge clk_i);
    end

    // PC-triggered mode
    sw = {rand_bits(32), rand_bits(32)} | 64'h8;
    trig = {rand_bits(30), 2'b00} | 32'h1000;
    pc = 32'h0000_0100;
    check_en = 1'b0;
    write_reg(irq_gen_pkg::REG_SW_LO, sw[31:0]);
    write_reg(irq_gen_pkg::REG_SW_HI, sw[63:32]);
    write_reg(irq_gen_pkg::REG_PC_TRIG, trig);
    for (int pass = 0; pass < 2; pass++) begin
      write_reg(irq_gen_pkg::REG_MODE, irq_gen_pkg::PC_TRIG);
      expect_lines('0);
      repeat (5) @(negedge clk_i);
      pc = trig;
      @(negedge clk_i);
      pc = 32'h0000_0200;
      exp_lines = map_word(sw);
      repeat (2 + rand_bits(3)) @(negedge clk_i);
      id = rand_bits(6);
      pulse_ack(id);
      exp_lines = '0;
      check_read(irq_gen_pkg::REG_ACK_ID, 32'(id), irq_gen_pkg::RESP_OKAY);
      // Disarmed, a second match stays silent
      pc = trig;
      @(negedge clk_i);
      pc = 32'h0000_0300;
      repeat (4) @(negedge clk_i);
    end

    // Random mode, four rounds of ten interrupts with new bounds
    for (int round = 0; round < 4; round++) begin
      check_en = 1'b0;
      write_reg(irq_gen_pkg::REG_MODE, irq_gen_pkg::STANDARD);
      min_c = rand_bits(6);
      min_i = rand_bits(6) % 41;
      max_i = (min_i < 16) ? 16 : min_i;
      max_i = max_i + rand_bits(6) % (64 - max_i);
      write_reg(irq_gen_pkg::REG_MIN_CYC, min_c);
      write_reg(irq_gen_pkg::REG_MAX_CYC, min_c + rand_bits(7));
      write_reg(irq_gen_pkg::REG_MIN_ID, min_i);
      write_reg(irq_gen_pkg::REG_MAX_ID, max_i);
      write_reg(irq_gen_pkg::REG_MODE, irq_gen_pkg::RANDOM);
      ref_cyc = fire_cyc;
      repeat (10) begin
        while (irq_lines == '0) @(negedge clk_i);
        if (cyc - ref_cyc < min_c + 2) begin
          err_rnd++;
          $display("Random lines rose %0d cycles after ack or entry, minimum %0d",
                   cyc - ref_cyc, min_c + 2);
        end
        val = irq_lines;
        if (!rnd_legal(val, min_i, max_i)) begin
          err_rnd++;
          $display("FAIL %0t irq_lines_o outside ids %0d..%0d got %h",
                   $time, min_i, max_i, val);
        end
        repeat (rand_bits(3)) begin
          @(negedge clk_i);
          if (irq_lines !== val) begin
            err_rnd++;
            $display("FAIL %0t irq_lines_o expected %h got %h", $time, val, irq_lines);
          end
        end
        id = rand_bits(6);
        ref_cyc = cyc;
        pulse_ack(id);
        if (irq_lines !== '0) begin
          err_rnd++;
          $display("FAIL %0t irq_lines_o expected %h got %h", $time, 51'h0, irq_lines);
        end
        check_read(irq_gen_pkg::REG_ACK_ID, 32'(id), irq_gen_pkg::RESP_OKAY);
      end
      write_reg(irq_gen_pkg::REG_MODE, irq_gen_pkg::STANDARD);
      expect_lines('0);
      repeat (4) @(negedge clk_i);
    end

    if (err_lines + err_bus + err_rnd == 0) begin
      $display("Errors: lines %0d, bus %0d, random %0d", err_lines, err_bus, err_rnd);
      $display("** PASS **");
    end else begin
      $display("Errors: lines %0d, bus %0d, random %0d", err_lines, err_bus, err_rnd);
      $display("** FAIL **");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* bench/irq_gen_sva.sv */
// Interrupt generator bound assertions
// AXI4-Lite response hold rules, standard mode silence and
// stable PC-triggered lines until the core acknowledges

`timescale 1ns/1ps
`default_nettype none

module irq_gen_sva (
  input logic                    clk_i,
  input logic                    rst_ni,
  input irq_gen_pkg::axil_req_t  axil_req_i,
  input irq_gen_pkg::axil_rsp_t  axil_rsp_o,
  input logic                    irq_ack_i,
  input irq_gen_pkg::irq_cfg_t   cfg_i,
  input irq_gen_pkg::irq_lines_t irq_lines_o
);

  ////////////////////////////////////////////////////////////
  // AXI4-Lite response channels
  ////////////////////////////////////////////////////////////

  // Write response waits for b_ready
  a_b_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
    axil_rsp_o.b_valid && !axil_req_i.b_ready |=>
      axil_rsp_o.b_valid && $stable(axil_rsp_o.b_resp))
    else $error("write response dropped before b_ready");

  // Read response and its data wait for r_ready
  a_r_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
    axil_rsp_o.r_valid && !axil_req_i.r_ready |=>
      axil_rsp_o.r_valid && $stable(axil_rsp_o.r_data))
    else $error("read response dropped before r_ready");

  ////////////////////////////////////////////////////////////
  // Line rules
  ////////////////////////////////////////////////////////////

  // Second sample in STANDARD sees the output register cleared
  a_std_zero: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (cfg_i.mode == irq_gen_pkg::STANDARD) [*2] |-> irq_lines_o == '0)
    else $error("lines active in standard mode");

  // Fired trigger lines hold until the ack
  a_pc_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (cfg_i.mode == irq_gen_pkg::PC_TRIG) [*2] ##0
      (irq_lines_o != '0 && !irq_ack_i) |=> $stable(irq_lines_o))
    else $error("PC-triggered lines changed without an ack");

endmodule

bind irq_gen_top irq_gen_sva u_sva (
  .clk_i       (clk_i),
  .rst_ni      (rst_ni),
  .axil_req_i  (axil_req_i),
  .axil_rsp_o  (axil_rsp_o),
  .irq_ack_i   (irq_ack_i),
  .cfg_i       (cfg),
  .irq_lines_o (irq_lines_o)
);

`default_nettype wire

/* rtl/irq_gen_top.sv */
// Interrupt generator top level
// Register block on AXI4-Lite, random source and mode controller.
// Drives the core interrupt line bundle and takes its acknowledge.

`timescale 1ns/1ps
`default_nettype none

module irq_gen_top #(
  parameter logic [31:0] LFSR_SEED = 32'h5A3C_96E1
) (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  irq_gen_pkg::axil_req_t  axil_req_i,
  output irq_gen_pkg::axil_rsp_t  axil_rsp_o,
  input  irq_gen_pkg::pc_t        pc_i,
  input  logic                    irq_ack_i,
  input  irq_gen_pkg::irq_id_t    irq_ack_id_i,
  output irq_gen_pkg::irq_lines_t irq_lines_o
);

  irq_gen_pkg::irq_cfg_t  cfg;
  irq_gen_pkg::irq_word_t rnd_word;
  logic                   rnd_valid;

  // Configuration registers and ack id capture
  irq_gen_regs u_regs (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .axil_req_i (axil_req_i),
    .axil_rsp_o (axil_rsp_o),
    .ack_i      (irq_ack_i),
    .ack_id_i   (irq_ack_id_i),
    .cfg_o      (cfg)
  );

  // Random mode word and delay
  irq_rnd_source #(
    .LFSR_SEED (LFSR_SEED)
  ) u_rnd_source (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .cfg_i       (cfg),
    .ack_i       (irq_ack_i),
    .rnd_word_o  (rnd_word),
    .rnd_valid_o (rnd_valid)
  );

  // Mode select and line register
  irq_mode_ctrl u_mode_ctrl (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .cfg_i       (cfg),
    .rnd_word_i  (rnd_word),
    .rnd_valid_i (rnd_valid),
    .pc_i        (pc_i),
    .ack_i       (irq_ack_i),
    .irq_lines_o (irq_lines_o)
  );

endmodule

`default_nettype wire

/* rtl/irq_mode_ctrl.sv */
// Interrupt mode controller
// Maps interrupt words onto the core line bundle, selects the source by
// mode and registers the result. Owns the PC trigger, which arms on a
// mode write and fires once on a program counter match.

`timescale 1ns/1ps
`default_nettype none

module irq_mode_ctrl (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  irq_gen_pkg::irq_cfg_t  cfg_i,
  input  irq_gen_pkg::irq_word_t rnd_word_i,
  input  logic                   rnd_valid_i,
  input  irq_gen_pkg::pc_t       pc_i,
  input  logic                   ack_i,
  output irq_gen_pkg::irq_lines_t irq_lines_o
);

  logic                    armed_q;
  logic                    fire;
  irq_gen_pkg::irq_lines_t trig_q;
  irq_gen_pkg::irq_lines_t trig_d;
  irq_gen_pkg::irq_lines_t lines_d;
  irq_gen_pkg::irq_lines_t lines_q;

  // Word bits 3, 7, 11 and 16 to 63 drive the lines, the rest is dropped
  function automatic irq_gen_pkg::irq_lines_t map_word(irq_gen_pkg::irq_word_t w);
    irq_gen_pkg::irq_lines_t l;
    l.software = w[3];
    l.timer    = w[7];
    l.external = w[11];
    l.fast     = w[63:16];
    return l;
  endfunction

  ////////////////////////////////////////////////////////////
  // PC trigger
  ////////////////////////////////////////////////////////////

  assign fire = armed_q && (cfg_i.mode == irq_gen_pkg::PC_TRIG) &&
                (pc_i == cfg_i.pc_trig);

  // Latched lines held until the core acknowledges
  always_comb begin
    trig_d = trig_q;
    if (cfg_i.mode != irq_gen_pkg::PC_TRIG) begin
      trig_d = '0;
    end else if (fire) begin
      trig_d = map_word(cfg_i.sw_word);
    end else if (ack_i) begin
      trig_d = '0;
    end
  end

  ////////////////////////////////////////////////////////////
  // Source select
  ////////////////////////////////////////////////////////////

  always_comb begin
    unique case (cfg_i.mode)
      irq_gen_pkg::RANDOM: begin
        // Drop in the ack cycle, ahead of rnd_valid_i falling
        lines_d = (rnd_valid_i && !ack_i) ? map_word(rnd_word_i) : '0;
      end
      irq_gen_pkg::PC_TRIG:          lines_d = trig_d;
      irq_gen_pkg::SOFTWARE_DEFINED: lines_d = map_word(cfg_i.sw_word);
      default:                       lines_d = '0;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      armed_q <= 1'b0;
      trig_q  <= '0;
      lines_q <= '0;
    end else begin
      // Re-armed by each mode write, one shot per arm
      if (cfg_i.mode_wr) begin
        armed_q <= (cfg_i.mode == irq_gen_pkg::PC_TRIG);
      end else if (fire) begin
        armed_q <= 1'b0;
      end
      trig_q  <= trig_d;
      lines_q <= lines_d;
    end
  end

  // Registered, glitch-free pins
  assign irq_lines_o = lines_q;

endmodule

`default_nettype wire

/* rtl/irq_rnd_source.sv */
// Random interrupt source
// A 32-bit Galois LFSR draws an id-bounded word with at least one
// mapped line set, plus a delay bounded by the configured cycle range.
// The word is released after the delay and held until acknowledged.

`timescale 1ns/1ps
`default_nettype none

module irq_rnd_source #(
  parameter logic [31:0] LFSR_SEED = 32'h0000_0001
) (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  irq_gen_pkg::irq_cfg_t cfg_i,
  input  logic                  ack_i,
  output irq_gen_pkg::irq_word_t rnd_word_o,
  output logic                  rnd_valid_o
);

  // x^32 + x^22 + x^2 + x + 1
  localparam logic [31:0] LFSR_TAPS = 32'h8020_0003;
  // Word bits that reach a line: 3, 7, 11 and 16 to 63
  localparam irq_gen_pkg::irq_word_t MAPPED_MASK = 64'hFFFF_FFFF_FFFF_0888;

  irq_gen_pkg::rnd_state_e state_q;
  irq_gen_pkg::rnd_state_e state_d;
  logic [31:0]             lfsr_q;
  irq_gen_pkg::irq_word_t  word_q;
  irq_gen_pkg::cycle_cnt_t cnt_q;

  irq_gen_pkg::irq_word_t  id_mask;
  irq_gen_pkg::irq_word_t  draw_word;
  irq_gen_pkg::cycle_cnt_t limit;
  irq_gen_pkg::cycle_cnt_t span;
  irq_gen_pkg::cycle_cnt_t span_mask;
  logic [16:0]             delay_sum;
  logic                    draw_ok;

  ////////////////////////////////////////////////////////////
  // Draw
  ////////////////////////////////////////////////////////////

  // Ids from min_id to max_id inclusive
  always_comb begin
    for (int i = 0; i < 64; i++) begin
      id_mask[i] = (6'(i) >= cfg_i.min_id) && (6'(i) <= cfg_i.max_id);
    end
  end

  // Upper half is the state rotated by 16
  assign draw_word = {lfsr_q[15:0], lfsr_q[31:16], lfsr_q} & id_mask;

  // Max below min collapses the range onto min
  assign limit = (cfg_i.max_cycles >= cfg_i.min_cycles) ? cfg_i.max_cycles
                                                        : cfg_i.min_cycles;
  assign span  = limit - cfg_i.min_cycles;

  // Smallest all-ones mask covering the span
  always_comb begin
    span_mask = span;
    span_mask = span_mask | (span_mask >> 1);
    span_mask = span_mask | (span_mask >> 2);
    span_mask = span_mask | (span_mask >> 4);
    span_mask = span_mask | (span_mask >> 8);
  end

  assign delay_sum = {1'b0, cfg_i.min_cycles} + {1'b0, lfsr_q[23:8] & span_mask};

  // Redraw on no mapped line or a delay past the upper bound
  assign draw_ok = |(draw_word & MAPPED_MASK) && (delay_sum <= {1'b0, limit});

  ////////////////////////////////////////////////////////////
  // FSM
  ////////////////////////////////////////////////////////////

  always_comb begin
    state_d = state_q;
    unique case (state_q)
      irq_gen_pkg::RND_OFF: begin
        if (cfg_i.mode == irq_gen_pkg::RANDOM) state_d = irq_gen_pkg::RND_DRAW;
      end
      irq_gen_pkg::RND_DRAW: begin
        if (draw_ok) state_d = irq_gen_pkg::RND_DELAY;
      end
      irq_gen_pkg::RND_DELAY: begin
        if (cnt_q == '0) state_d = irq_gen_pkg::RND_HOLD;
      end
      irq_gen_pkg::RND_HOLD: begin
        if (ack_i) state_d = irq_gen_pkg::RND_DRAW;
      end
    endcase
    // Leaving RANDOM mode stops the source from any state
    if (cfg_i.mode != irq_gen_pkg::RANDOM) begin
      state_d = irq_gen_pkg::RND_OFF;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= irq_gen_pkg::RND_OFF;
      lfsr_q  <= LFSR_SEED;
      cnt_q   <= '0;
    end else begin
      state_q <= state_d;
      if (state_q == irq_gen_pkg::RND_DRAW) begin
        // One step per draw
        lfsr_q <= {1'b0, lfsr_q[31:1]} ^ (lfsr_q[0] ? LFSR_TAPS : 32'h0);
        if (draw_ok) begin
          cnt_q <= delay_sum[15:0];
        end
      end else if (state_q == irq_gen_pkg::RND_DELAY && cnt_q != '0) begin
        cnt_q <= cnt_q - 16'd1;
      end
    end
  end

  // Accepted word, qualified by rnd_valid_o
  always_ff @(posedge clk_i) begin
    if (state_q == irq_gen_pkg::RND_DRAW && draw_ok) begin
      word_q <= draw_word;
    end
  end

  assign rnd_word_o  = word_q;
  assign rnd_valid_o = (state_q == irq_gen_pkg::RND_HOLD);

endmodule

`default_nettype wire

/* rtl/irq_gen_regs.sv */
// Interrupt generator register block
// AXI4-Lite slave with one outstanding write and one outstanding read.
// Holds the configuration registers with byte strobes, pulses mode_wr
// on a mode write and captures the id of each core acknowledge.

`timescale 1ns/1ps
`default_nettype none

module irq_gen_regs (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  irq_gen_pkg::axil_req_t axil_req_i,
  output irq_gen_pkg::axil_rsp_t axil_rsp_o,
  input  logic                   ack_i,
  input  irq_gen_pkg::irq_id_t   ack_id_i,
  output irq_gen_pkg::irq_cfg_t  cfg_o
);

  irq_gen_pkg::irq_cfg_t   cfg_q;
  irq_gen_pkg::irq_id_t    ack_id_q;

  logic                    wr_fire;
  logic                    rd_fire;
  logic                    wr_hit;
  logic                    rd_hit;
  irq_gen_pkg::axil_data_t wr_val;

  logic                    b_valid_q;
  irq_gen_pkg::axil_resp_t b_resp_q;
  logic                    r_valid_q;
  irq_gen_pkg::axil_resp_t r_resp_q;
  irq_gen_pkg::axil_data_t r_data_q;

  ////////////////////////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////////////////////////

  // Current register contents, zero extended to the bus width
  function automatic irq_gen_pkg::axil_data_t reg_value(
    irq_gen_pkg::irq_cfg_t   cfg,
    irq_gen_pkg::irq_id_t    ack_id,
    irq_gen_pkg::axil_addr_t addr
  );
    irq_gen_pkg::axil_data_t val;
    val = '0;
    case (addr)
      irq_gen_pkg::REG_MODE:    val = 32'(cfg.mode);
      irq_gen_pkg::REG_MIN_CYC: val = 32'(cfg.min_cycles);
      irq_gen_pkg::REG_MAX_CYC: val = 32'(cfg.max_cycles);
      irq_gen_pkg::REG_MIN_ID:  val = 32'(cfg.min_id);
      irq_gen_pkg::REG_MAX_ID:  val = 32'(cfg.max_id);
      irq_gen_pkg::REG_PC_TRIG: val = cfg.pc_trig;
      irq_gen_pkg::REG_SW_LO:   val = cfg.sw_word[31:0];
      irq_gen_pkg::REG_SW_HI:   val = cfg.sw_word[63:32];
      irq_gen_pkg::REG_ACK_ID:  val = 32'(ack_id);
      default:                  val = '0;
    endcase
    return val;
  endfunction

  // Merge new bytes into the old value under the write strobes
  function automatic irq_gen_pkg::axil_data_t apply_strb(
    irq_gen_pkg::axil_data_t old,
    irq_gen_pkg::axil_data_t data,
    irq_gen_pkg::axil_strb_t strb
  );
    irq_gen_pkg::axil_data_t res;
    res = old;
    for (int i = 0; i < 4; i++) begin
      if (strb[i]) begin
        res[8*i +: 8] = data[8*i +: 8];
      end
    end
    return res;
  endfunction

  ////////////////////////////////////////////////////////////
  // Decode
  ////////////////////////////////////////////////////////////

  // Accept only with no response waiting
  assign wr_fire = axil_req_i.aw_valid && axil_req_i.w_valid && !b_valid_q;
  assign rd_fire = axil_req_i.ar_valid && !r_valid_q;

  // Writable registers; REG_ACK_ID is read only
  assign wr_hit = (axil_req_i.aw_addr[1:0] == 2'b00) &&
                  (axil_req_i.aw_addr <= irq_gen_pkg::REG_SW_HI);
  assign rd_hit = (axil_req_i.ar_addr[1:0] == 2'b00) &&
                  (axil_req_i.ar_addr <= irq_gen_pkg::REG_ACK_ID);

  assign wr_val = apply_strb(reg_value(cfg_q, ack_id_q, axil_req_i.aw_addr),
                             axil_req_i.w_data, axil_req_i.w_strb);

  ////////////////////////////////////////////////////////////
  // Configuration and acknowledge capture
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cfg_q    <= '0;
      ack_id_q <= '0;
    end else begin
      cfg_q.mode_wr <= 1'b0;
      if (wr_fire) begin
        case (axil_req_i.aw_addr)
          irq_gen_pkg::REG_MODE: begin
            cfg_q.mode    <= irq_gen_pkg::irq_mode_e'(wr_val[1:0]);
            cfg_q.mode_wr <= 1'b1;
          end
          irq_gen_pkg::REG_MIN_CYC: cfg_q.min_cycles <= wr_val[15:0];
          irq_gen_pkg::REG_MAX_CYC: cfg_q.max_cycles <= wr_val[15:0];
          irq_gen_pkg::REG_MIN_ID:  cfg_q.min_id <= wr_val[5:0];
          irq_gen_pkg::REG_MAX_ID:  cfg_q.max_id <= wr_val[5:0];
          irq_gen_pkg::REG_PC_TRIG: cfg_q.pc_trig <= wr_val;
          irq_gen_pkg::REG_SW_LO:   cfg_q.sw_word[31:0] <= wr_val;
          irq_gen_pkg::REG_SW_HI:   cfg_q.sw_word[63:32] <= wr_val;
          default: ;
        endcase
      end
      // Any mode, readable from the next cycle
      if (ack_i) begin
        ack_id_q <= ack_id_i;
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // Response channels
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      b_valid_q <= 1'b0;
      b_resp_q  <= irq_gen_pkg::RESP_OKAY;
      r_valid_q <= 1'b0;
      r_resp_q  <= irq_gen_pkg::RESP_OKAY;
    end else begin
      if (wr_fire) begin
        b_valid_q <= 1'b1;
        b_resp_q  <= wr_hit ? irq_gen_pkg::RESP_OKAY : irq_gen_pkg::RESP_SLVERR;
      end else if (axil_req_i.b_ready) begin
        b_valid_q <= 1'b0;
      end
      if (rd_fire) begin
        r_valid_q <= 1'b1;
        r_resp_q  <= rd_hit ? irq_gen_pkg::RESP_OKAY : irq_gen_pkg::RESP_SLVERR;
      end else if (axil_req_i.r_ready) begin
        r_valid_q <= 1'b0;
      end
    end
  end

  // Read data held with r_valid, unmapped addresses read zero
  always_ff @(posedge clk_i) begin
    if (rd_fire) begin
      r_data_q <= reg_value(cfg_q, ack_id_q, axil_req_i.ar_addr);
    end
  end

  assign axil_rsp_o.aw_ready = wr_fire;
  assign axil_rsp_o.w_ready  = wr_fire;
  assign axil_rsp_o.b_resp   = b_resp_q;
  assign axil_rsp_o.b_valid  = b_valid_q;
  assign axil_rsp_o.ar_ready = rd_fire;
  assign axil_rsp_o.r_data   = r_data_q;
  assign axil_rsp_o.r_resp   = r_resp_q;
  assign axil_rsp_o.r_valid  = r_valid_q;

  assign cfg_o = cfg_q;

endmodule

`default_nettype wire

/* rtl/irq_gen_pkg.sv */
// Interrupt generator shared definitions
// Widths with a meaning, mode and random source encodings, the physical
// interrupt line bundle, the configuration bundle, AXI4-Lite channels
// and the register map

`default_nettype none

package irq_gen_pkg;

  ////////////////////////////////////////////////////////////
  // Widths
  ////////////////////////////////////////////////////////////

  // Interrupt word, bit n stands for interrupt id n
  typedef logic [63:0] irq_word_t;
  typedef logic [5:0]  irq_id_t;
  // Delay in clock cycles
  typedef logic [15:0] cycle_cnt_t;
  typedef logic [31:0] pc_t;

  // AXI4-Lite fields
  typedef logic [7:0]  axil_addr_t;
  typedef logic [31:0] axil_data_t;
  typedef logic [3:0]  axil_strb_t;
  typedef logic [1:0]  axil_resp_t;

  localparam axil_resp_t RESP_OKAY   = 2'b00;
  localparam axil_resp_t RESP_SLVERR = 2'b10;

  ////////////////////////////////////////////////////////////
  // Encodings
  ////////////////////////////////////////////////////////////

  typedef enum logic [1:0] {
    STANDARD         = 2'd0,
    RANDOM           = 2'd1,
    PC_TRIG          = 2'd2,
    SOFTWARE_DEFINED = 2'd3
  } irq_mode_e;

  // Random source states, RND_OFF is the idle state out of reset
  typedef enum logic [1:0] {
    RND_DRAW,
    RND_DELAY,
    RND_HOLD,
    RND_OFF
  } rnd_state_e;

  ////////////////////////////////////////////////////////////
  // Bundles
  ////////////////////////////////////////////////////////////

  // Core interrupt pins
  typedef struct packed {
    logic        software;
    logic        timer;
    logic        external;
    logic [47:0] fast;
  } irq_lines_t;

  typedef struct packed {
    irq_mode_e  mode;
    cycle_cnt_t min_cycles;
    cycle_cnt_t max_cycles;
    irq_id_t    min_id;
    irq_id_t    max_id;
    pc_t        pc_trig;
    irq_word_t  sw_word;
    // One cycle pulse on a mode register write
    logic       mode_wr;
  } irq_cfg_t;

  // Master to slave
  typedef struct packed {
    axil_addr_t aw_addr;
    logic       aw_valid;
    axil_data_t w_data;
    axil_strb_t w_strb;
    logic       w_valid;
    logic       b_ready;
    axil_addr_t ar_addr;
    logic       ar_valid;
    logic       r_ready;
  } axil_req_t;

  // Slave to master
  typedef struct packed {
    logic       aw_ready;
    logic       w_ready;
    axil_resp_t b_resp;
    logic       b_valid;
    logic       ar_ready;
    axil_data_t r_data;
    axil_resp_t r_resp;
    logic       r_valid;
  } axil_rsp_t;

  ////////////////////////////////////////////////////////////
  // Register map
  ////////////////////////////////////////////////////////////

  localparam axil_addr_t REG_MODE    = 8'h00;
  localparam axil_addr_t REG_MIN_CYC = 8'h04;
  localparam axil_addr_t REG_MAX_CYC = 8'h08;
  localparam axil_addr_t REG_MIN_ID  = 8'h0C;
  localparam axil_addr_t REG_MAX_ID  = 8'h10;
  localparam axil_addr_t REG_PC_TRIG = 8'h14;
  localparam axil_addr_t REG_SW_LO   = 8'h18;
  localparam axil_addr_t REG_SW_HI   = 8'h1C;
  // Read only, last acknowledged id
  localparam axil_addr_t REG_ACK_ID  = 8'h20;

endpackage

`default_nettype wire
